// File: rtp_pkg.sv
// NS2009 touch panel controller shared definitions
// command and response structs, engine state encoding, sample width
`default_nettype none

package rtp_pkg;

    localparam int SAMPLE_W = 12;  // touch sample width in bits

    // host command, one per four-phase handshake
    typedef struct packed {
        logic       rw;        // 1 = read sample, 0 = write command byte
        logic [7:0] cmd_byte;  // command for writes, ignored for reads
    } rtp_cmd_t;

    // transfer result back to the host
    typedef struct packed {
        logic                rw;      // echo of command rw
        logic                nack;    // a master byte was not acknowledged
        logic [SAMPLE_W-1:0] sample;  // read value, zero otherwise
    } rtp_rsp_t;

    // bus engine sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,     // waiting for a command
        ST_START,    // start condition
        ST_ADDR,     // address byte plus device ack
        ST_WRITE,    // command byte plus device ack
        ST_READ_HI,  // first read byte, master ack
        ST_READ_LO,  // second read byte, master nack
        ST_STOP,     // stop condition
        ST_DONE      // response waiting for a free slot
    } eng_state_t;

endpackage

`default_nettype wire

// File: rtp_cmd_port.sv
// command port of the touch controller
// four-phase req/ack receiver, holds one command until the bus engine takes it
`timescale 1ns/10ps
`default_nettype none

module rtp_cmd_port (
    input  wire                clk,
    input  wire                arst_n,
    input  wire                cmd_req,
    input  wire rtp_pkg::rtp_cmd_t cmd,
    input  wire                xfer_take,
    output logic               cmd_ack,
    output rtp_pkg::rtp_cmd_t  xfer,
    output logic               xfer_valid
);

    typedef enum logic [1:0] {
        CP_IDLE,  // ready for a new request
        CP_HOLD,  // command offered to the engine
        CP_ACK    // ack high, waiting for req to fall
    } cp_state_t;

    cp_state_t state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= CP_IDLE;
        end else begin
            case (state)
                CP_IDLE: if (cmd_req) state <= CP_HOLD;   // req seen with ack low
                CP_HOLD: if (xfer_take) state <= CP_ACK;  // engine has it
                CP_ACK:  if (!cmd_req) state <= CP_IDLE;  // host closed the handshake
                default: state <= CP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == CP_IDLE && cmd_req) begin
            xfer <= cmd;  // cmd is stable while req is high
        end
    end

    assign xfer_valid = (state == CP_HOLD);
    assign cmd_ack    = (state == CP_ACK);

    // ack only answers a live request
    assert property (@(posedge clk) disable iff (!arst_n) $rose(cmd_ack) |-> cmd_req);

endmodule

`default_nettype wire

// File: i2c_rtp_engine.sv
// I2C bus engine for the NS2009 touch chip
// open-drain master: start, address, one command byte or two read bytes, stop
// quarter-bit tick divider, state/bit/phase sequencer and a byte shift register
`timescale 1ns/10ps
`default_nettype none

module i2c_rtp_engine #(
    parameter int         CLK_DIV  = 8,      // clocks per SCL quarter tick
    parameter logic [6:0] DEV_ADDR = 7'h48   // 7-bit device address
) (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire rtp_pkg::rtp_cmd_t xfer,
    input  wire                    xfer_valid,
    input  wire                    rsp_free,
    input  wire                    sda_in,
    input  wire                    scl_in,
    output logic                   xfer_take,
    output logic                   done,
    output rtp_pkg::rtp_rsp_t      rsp_in,
    output logic                   sda_oe,
    output logic                   scl_oe
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    rtp_pkg::eng_state_t          state;
    rtp_pkg::eng_state_t          ack_next;  // where the ack slot leads
    logic [DIV_W-1:0]             div_cnt;
    logic [1:0]                   phase;     // quarter within a bit or condition
    logic [3:0]                   bit_cnt;   // 0..7 data, 8 ack slot
    logic                         busy;
    logic                         tick;
    logic                         in_bit;
    logic                         ack_slot;
    logic                         bit_end;   // sample point, scl high
    logic                         bit_sda;   // sda enable for the current bit
    logic                         rw_q;
    logic [7:0]                   cmd_q;
    logic [7:0]                   sh;        // address/data shifter, msb first
    logic [rtp_pkg::SAMPLE_W-1:0] sample;
    logic                         nack;

    assign busy      = (state != rtp_pkg::ST_IDLE) && (state != rtp_pkg::ST_DONE);
    assign tick      = busy && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign in_bit    = state inside {rtp_pkg::ST_ADDR, rtp_pkg::ST_WRITE,
                                     rtp_pkg::ST_READ_HI, rtp_pkg::ST_READ_LO};
    assign ack_slot  = (bit_cnt == 4'd8);
    assign bit_end   = tick && in_bit && (phase == 2'd3);
    assign xfer_take = (state == rtp_pkg::ST_IDLE) && xfer_valid;
    assign done      = (state == rtp_pkg::ST_DONE) && rsp_free;  // held off by back-pressure
    assign rsp_in    = '{rw: rw_q, nack: nack, sample: sample};

    always_comb begin
        bit_sda  = 1'b0;                 // released: read data and final nack
        ack_next = rtp_pkg::ST_STOP;
        case (state)
            rtp_pkg::ST_ADDR: begin
                bit_sda = ack_slot ? 1'b0 : ~sh[7];  // release for device ack
                if (!sda_in) begin
                    ack_next = rw_q ? rtp_pkg::ST_READ_HI : rtp_pkg::ST_WRITE;
                end
            end
            rtp_pkg::ST_WRITE:   bit_sda = ack_slot ? 1'b0 : ~sh[7];
            rtp_pkg::ST_READ_HI: begin
                bit_sda  = ack_slot;     // master ack on first byte
                ack_next = rtp_pkg::ST_READ_LO;
            end
            default: ;
        endcase
    end

    // quarter tick divider, idle outside a transfer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (!busy || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= rtp_pkg::ST_IDLE;
            phase   <= 2'd0;
            bit_cnt <= 4'd0;
            sda_oe  <= 1'b0;
            scl_oe  <= 1'b0;
        end else begin
            case (state)
                rtp_pkg::ST_IDLE: begin
                    phase <= 2'd0;
                    if (xfer_valid) state <= rtp_pkg::ST_START;
                end
                rtp_pkg::ST_START: begin
                    if (tick) begin
                        if (phase == 2'd0) begin
                            sda_oe <= 1'b1;           // sda falls, scl high
                            phase  <= 2'd1;
                        end else begin
                            state   <= rtp_pkg::ST_ADDR;
                            phase   <= 2'd0;
                            bit_cnt <= 4'd0;
                        end
                    end
                end
                rtp_pkg::ST_STOP: begin
                    if (phase == 2'd1) sda_oe <= 1'b1;  // one clock after scl falls
                    if (tick) begin
                        case (phase)
                            2'd0: begin
                                scl_oe <= 1'b1;
                                phase  <= 2'd1;
                            end
                            2'd1: begin
                                scl_oe <= 1'b0;       // scl up, sda still low
                                phase  <= 2'd2;
                            end
                            default: begin
                                sda_oe <= 1'b0;       // sda rises, stop
                                state  <= rtp_pkg::ST_DONE;
                            end
                        endcase
                    end
                end
                rtp_pkg::ST_DONE: begin
                    if (rsp_free) state <= rtp_pkg::ST_IDLE;
                end
                default: begin                        // the four bit states
                    if (tick) begin
                        phase <= phase + 2'd1;
                        case (phase)
                            2'd0: scl_oe <= 1'b1;     // scl low
                            2'd1: sda_oe <= bit_sda;  // data moves only under scl low
                            2'd2: scl_oe <= 1'b0;     // scl high
                            default: begin            // sample point
                                if (ack_slot) begin
                                    bit_cnt <= 4'd0;
                                    state   <= ack_next;  // a device nack jumps to stop
                                end else begin
                                    bit_cnt <= bit_cnt + 4'd1;
                                end
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // transfer payload
    always_ff @(posedge clk) begin
        if (xfer_take) begin
            rw_q   <= xfer.rw;
            cmd_q  <= xfer.cmd_byte;
            sh     <= {DEV_ADDR, xfer.rw};
            nack   <= 1'b0;
            sample <= '0;
        end else if (bit_end) begin
            if (!ack_slot) begin
                sh <= {sh[6:0], sda_in};              // out on msb, in on lsb
            end else begin
                case (state)
                    rtp_pkg::ST_ADDR: begin
                        nack <= sda_in;
                        sh   <= cmd_q;
                    end
                    rtp_pkg::ST_WRITE:   nack <= sda_in;
                    rtp_pkg::ST_READ_HI: sample[rtp_pkg::SAMPLE_W-1:4] <= sh;
                    default:             sample[3:0] <= sh[7:4];  // upper nibble only
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        (!scl_oe && !$past(scl_oe)
            && !($past(state) inside {rtp_pkg::ST_START, rtp_pkg::ST_STOP}))
            |-> $stable(sda_oe));

    // done is a single pulse and the response port takes the slot
    assert property (@(posedge clk) disable iff (!arst_n) done |=> !done && !rsp_free);

    // no stretching on this device, scl is high at every sample point
    assert property (@(posedge clk) disable iff (!arst_n) bit_end |-> scl_in);

endmodule

`default_nettype wire

// File: rtp_rsp_port.sv
// response port of the touch controller
// holds one response and hands it to the host over a four-phase req/ack
`timescale 1ns/10ps
`default_nettype none

module rtp_rsp_port (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    done,
    input  wire rtp_pkg::rtp_rsp_t rsp_in,
    input  wire                    rsp_ack,
    output logic                   rsp_free,
    output rtp_pkg::rtp_rsp_t      rsp,
    output logic                   rsp_req
);

    typedef enum logic [1:0] {
        RP_FREE,  // slot empty
        RP_REQ,   // response offered, req high
        RP_WAIT   // req dropped, waiting for ack to fall
    } rp_state_t;

    rp_state_t state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= RP_FREE;
        end else begin
            case (state)
                RP_FREE: if (done) state <= RP_REQ;      // req high next cycle
                RP_REQ:  if (rsp_ack) state <= RP_WAIT;  // host took it
                RP_WAIT: if (!rsp_ack) state <= RP_FREE; // handshake closed
                default: state <= RP_FREE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            rsp <= rsp_in;  // engine only pulses done while free
        end
    end

    assign rsp_req  = (state == RP_REQ);
    assign rsp_free = (state == RP_FREE);

    // response held for the whole request
    assert property (@(posedge clk) disable iff (!arst_n)
        rsp_req && $past(rsp_req) |-> $stable(rsp));

endmodule

`default_nettype wire

// File: rtp_top.sv
// NS2009 touch panel controller top level
// command port -> I2C bus engine -> response port
// bus pins as separate open-drain enables and line inputs
`timescale 1ns/10ps
`default_nettype none

module rtp_top #(
    parameter int         CLK_DIV  = 8,      // clocks per SCL quarter tick
    parameter logic [6:0] DEV_ADDR = 7'h48   // NS2009 address
) (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    cmd_req,
    input  wire rtp_pkg::rtp_cmd_t cmd,
    input  wire                    rsp_ack,
    input  wire                    sda_in,
    input  wire                    scl_in,
    output logic                   cmd_ack,
    output logic                   rsp_req,
    output rtp_pkg::rtp_rsp_t      rsp,
    output logic                   sda_oe,
    output logic                   scl_oe
);

    rtp_pkg::rtp_cmd_t xfer;
    logic              xfer_valid;
    logic              xfer_take;
    rtp_pkg::rtp_rsp_t rsp_in;
    logic              done;
    logic              rsp_free;   // back-pressure into the engine

    rtp_cmd_port u_cmd_port (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .xfer_take  (xfer_take),
        .cmd_ack    (cmd_ack),
        .xfer       (xfer),
        .xfer_valid (xfer_valid)
    );

    i2c_rtp_engine #(
        .CLK_DIV  (CLK_DIV),
        .DEV_ADDR (DEV_ADDR)
    ) u_engine (
        .clk        (clk),
        .arst_n     (arst_n),
        .xfer       (xfer),
        .xfer_valid (xfer_valid),
        .rsp_free   (rsp_free),
        .sda_in     (sda_in),
        .scl_in     (scl_in),
        .xfer_take  (xfer_take),
        .done       (done),
        .rsp_in     (rsp_in),
        .sda_oe     (sda_oe),
        .scl_oe     (scl_oe)
    );

    rtp_rsp_port u_rsp_port (
        .clk      (clk),
        .arst_n   (arst_n),
        .done     (done),
        .rsp_in   (rsp_in),
        .rsp_ack  (rsp_ack),
        .rsp_free (rsp_free),
        .rsp      (rsp),
        .rsp_req  (rsp_req)
    );

endmodule

`default_nettype wire

// File: tb_ns2009_model.sv
// NS2009 touch chip model for the testbench
// I2C slave that acks its address, records written bytes and returns a 12-bit sample
// also checks start/stop framing and flags SDA moving under a high SCL
`timescale 1ns/10ps
`default_nettype none

module tb_ns2009_model #(
    parameter logic [6:0] ADDR = 7'h48   // device address
) (
    input  wire        clk,
    input  wire        arst_n,
    input  wire        sda,         // resolved bus line
    input  wire        scl,
    input  wire        nack_mode,   // refuse the address
    input  wire [11:0] sample,      // value for the next read
    output logic       sda_oe,      // 1 pulls sda low
    output logic       bus_err,     // sticky rule violation
    output logic [7:0] start_cnt,   // starts seen so far
    output logic [7:0] wr_byte,     // last acked command byte
    output logic [7:0] wr_cnt,
    output logic [7:0] last_len,    // bytes completed before the last stop
    output logic       in_xfer
);

    logic        sda_q;
    logic        scl_q;
    logic [3:0]  bit_cnt;   // 8 = ack slot
    logic [2:0]  byte_idx;  // 0 = address byte
    logic [7:0]  shift;
    logic [15:0] rd_q;      // read data, msb out first
    logic        rw;
    logic        acked;
    logic        nack_q;
    logic        addr_hit;

    assign addr_hit = (shift[7:1] == ADDR) && !nack_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sda_q     <= 1'b1;
            scl_q     <= 1'b1;
            bit_cnt   <= 4'd0;
            byte_idx  <= 3'd0;
            shift     <= 8'd0;
            rd_q      <= 16'd0;
            rw        <= 1'b0;
            acked     <= 1'b0;
            nack_q    <= 1'b0;
            sda_oe    <= 1'b0;
            bus_err   <= 1'b0;
            start_cnt <= 8'd0;
            wr_byte   <= 8'd0;
            wr_cnt    <= 8'd0;
            last_len  <= 8'd0;
            in_xfer   <= 1'b0;
        end else begin
            sda_q <= sda;
            scl_q <= scl;
            if (scl && scl_q && sda_q && !sda) begin            // start
                if (in_xfer) begin
                    $display("bus rule: start inside a transfer, stop missing");
                    bus_err <= 1'b1;
                end
                in_xfer   <= 1'b1;
                bit_cnt   <= 4'd0;
                byte_idx  <= 3'd0;
                acked     <= 1'b0;
                sda_oe    <= 1'b0;
                nack_q    <= nack_mode;
                rd_q      <= {sample, 4'h0};                   // low nibble zero
                start_cnt <= start_cnt + 8'd1;
            end else if (scl && scl_q && !sda_q && sda) begin   // stop
                if (!in_xfer || bit_cnt != 4'd1) begin          // stop's scl pulse counts once
                    $display("bus rule: stop without a start or inside a byte");
                    bus_err <= 1'b1;
                end
                in_xfer  <= 1'b0;
                sda_oe   <= 1'b0;
                last_len <= {5'd0, byte_idx};
            end else if (!scl_q && scl) begin                   // scl rising
                if (!in_xfer) begin
                    $display("bus rule: clock pulse outside a transfer");
                    bus_err <= 1'b1;
                end
                if (bit_cnt == 4'd8) begin
                    bit_cnt  <= 4'd0;
                    byte_idx <= byte_idx + 3'd1;
                end else begin
                    shift   <= {shift[6:0], sda};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (scl_q && !scl && in_xfer) begin        // scl falling
                if (bit_cnt == 4'd8) begin
                    if (byte_idx == 3'd0) begin
                        rw     <= shift[0];
                        acked  <= addr_hit;
                        sda_oe <= addr_hit;                     // address ack
                    end else if (!rw && acked) begin
                        sda_oe  <= 1'b1;                        // command byte ack
                        wr_byte <= shift;
                        wr_cnt  <= wr_cnt + 8'd1;
                    end else begin
                        sda_oe <= 1'b0;                         // master acks reads
                    end
                end else if (rw && acked && byte_idx != 3'd0 && byte_idx < 3'd3) begin
                    sda_oe <= ~rd_q[15];
                    rd_q   <= {rd_q[14:0], 1'b0};
                end else begin
                    sda_oe <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_rtp.sv
// testbench for the NS2009 touch panel controller
// random writes and reads against the chip model, then a block with the address refused
// responses are checked in order against a reference, with random ack delays
`timescale 1ns/10ps
`default_nettype none

module tb_rtp;

    localparam int         CLK_DIV    = 8;
    localparam logic [6:0] DEV_ADDR   = 7'h48;
    localparam int         N_XFER     = 60;
    localparam int         N_ACKED    = 40;                  // then nack mode
    localparam int         READ_TICKS = 2 + 27 * 4 + 3;      // start, 27 bits, stop
    localparam int         MAX_DLY    = 1023;                // longest random ack delay
    localparam int         TIMEOUT    = N_XFER * (READ_TICKS * CLK_DIV + MAX_DLY + 64) + 200;

    logic              clk;
    logic              arst_n;
    logic              cmd_req;
    rtp_pkg::rtp_cmd_t cmd;
    logic              rsp_ack;
    logic              cmd_ack;
    logic              rsp_req;
    rtp_pkg::rtp_rsp_t rsp;
    logic              dut_sda_oe;
    logic              dut_scl_oe;
    logic              mdl_sda_oe;
    logic              sda_line;
    logic              scl_line;
    logic              nack_mode;
    logic              bus_err;
    logic              mdl_busy;
    logic [7:0]        start_cnt;
    logic [7:0]        wr_byte;
    logic [7:0]        wr_cnt;
    logic [7:0]        last_len;
    logic [11:0]       mdl_sample;

    rtp_pkg::rtp_cmd_t cmd_tab [0:255];
    logic [11:0]       sample_tab [0:255];
    logic [9:0]        delay_tab [0:255];   // ack delay in cycles, often longer than a transfer
    rtp_pkg::rtp_rsp_t exp_q [$];       // expected responses, in issue order
    int                idx_q [$];
    int                rsp_cnt;
    int                err_cnt;
    int                wr_seen;
    int unsigned       cycles;

    // open-drain lines with pull-ups
    assign sda_line   = ~(dut_sda_oe | mdl_sda_oe);
    assign scl_line   = ~dut_scl_oe;
    assign mdl_sample = sample_tab[start_cnt];   // latched by the model at start

    rtp_top #(
        .CLK_DIV  (CLK_DIV),
        .DEV_ADDR (DEV_ADDR)
    ) u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .rsp_ack (rsp_ack),
        .sda_in  (sda_line),
        .scl_in  (scl_line),
        .cmd_ack (cmd_ack),
        .rsp_req (rsp_req),
        .rsp     (rsp),
        .sda_oe  (dut_sda_oe),
        .scl_oe  (dut_scl_oe)
    );

    tb_ns2009_model #(
        .ADDR (DEV_ADDR)
    ) u_model (
        .clk       (clk),
        .arst_n    (arst_n),
        .sda       (sda_line),
        .scl       (scl_line),
        .nack_mode (nack_mode),
        .sample    (mdl_sample),
        .sda_oe    (mdl_sda_oe),
        .bus_err   (bus_err),
        .start_cnt (start_cnt),
        .wr_byte   (wr_byte),
        .wr_cnt    (wr_cnt),
        .last_len  (last_len),
        .in_xfer   (mdl_busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected response from the command, the model sample and the ack setting
    function automatic rtp_pkg::rtp_rsp_t expect_rsp(input rtp_pkg::rtp_cmd_t c,
                                                     input logic [11:0] s,
                                                     input logic refused);
        rtp_pkg::rtp_rsp_t r;
        r.rw     = c.rw;
        r.nack   = refused;
        r.sample = (c.rw && !refused) ? s : 12'd0;
        return r;
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rsp(input string name, input rtp_pkg::rtp_rsp_t got,
                             input rtp_pkg::rtp_rsp_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            err_cnt++;
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            err_cnt++;
            abort_run();
        end
    endtask

    // four-phase request, cmd set one cycle ahead of req
    task automatic send_cmd(input rtp_pkg::rtp_cmd_t c);
        @(posedge clk);
        cmd <= c;
        @(posedge clk);
        cmd_req <= 1'b1;
        do @(posedge clk); while (!cmd_ack);
        cmd_req <= 1'b0;
        do @(posedge clk); while (cmd_ack);
    endtask

    // bus rules and run length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (bus_err) begin
            $display("I2C bus rule broken, see the model report above");
            abort_run();
        end else if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, %0d responses received", cycles, rsp_cnt);
            abort_run();
        end
    end

    // response side, compares and acks after a random delay
    initial begin
        rtp_pkg::rtp_rsp_t exp;
        int                k;
        logic [7:0]        exp_len;
        rsp_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (rsp_req && !rsp_ack) begin
                if (exp_q.size() == 0) begin
                    $display("response arrived with no command pending");
                    abort_run();
                end
                exp = exp_q.pop_front();
                k   = idx_q.pop_front();
                check_rsp("rsp", rsp, exp);
                exp_len = exp.nack ? 8'd1 : (exp.rw ? 8'd3 : 8'd2);
                check_byte("bytes_per_xfer", last_len, exp_len);
                if (!exp.rw && !exp.nack) begin
                    wr_seen++;
                    check_byte("wr_byte", wr_byte, cmd_tab[k].cmd_byte);
                    check_byte("wr_cnt", wr_cnt, 8'(wr_seen));
                end
                repeat (delay_tab[k]) @(posedge clk);   // back-pressure
                rsp_ack <= 1'b1;
                while (rsp_req) @(posedge clk);
                rsp_ack <= 1'b0;
                rsp_cnt++;
            end
        end
    end

    initial begin
        logic [31:0] seed;
        arst_n    = 1'b0;
        cmd_req   = 1'b0;
        cmd       = '0;
        nack_mode = 1'b0;
        rsp_cnt   = 0;
        err_cnt   = 0;
        wr_seen   = 0;
        cycles    = 0;
        seed      = 32'hcfa38c6d;
        for (int i = 0; i < 256; i++) begin
            seed                  = lcg_next(seed);
            cmd_tab[i].rw         = seed[31];
            cmd_tab[i].cmd_byte   = seed[23:16];
            seed                  = lcg_next(seed);
            sample_tab[i]         = seed[27:16];
            seed                  = lcg_next(seed);
            delay_tab[i]          = seed[25:16];
        end
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < N_XFER; i++) begin
            if (i == N_ACKED) begin
                while (rsp_cnt != N_ACKED) @(posedge clk);   // bus idle before switching
                nack_mode <= 1'b1;
            end
            exp_q.push_back(expect_rsp(cmd_tab[i], sample_tab[i], i >= N_ACKED));
            idx_q.push_back(i);
            send_cmd(cmd_tab[i]);                            // next one goes out early
        end
        while (rsp_cnt != N_XFER) @(posedge clk);
        repeat (4) @(posedge clk);
        if (mdl_busy) begin
            $display("last transfer never saw a stop");
            err_cnt++;
        end
        if (err_cnt == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: files.f
rtp_pkg.sv
rtp_cmd_port.sv
i2c_rtp_engine.sv
rtp_rsp_port.sv
rtp_top.sv
tb_ns2009_model.sv
tb_rtp.sv

// File: Makefile
# Verilator flow for the NS2009 touch controller

VERILATOR ?= verilator
TOP       ?= tb_rtp
FILELIST  ?= files.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
